// File: design/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] dataWord;      // Register or PC value
    typedef logic [4:0]  regAddr;
    typedef logic [5:0]  opCode;
    typedef logic [5:0]  functCode;
    typedef logic [4:0]  aluOp;         // Class from the main decoder
    typedef logic [3:0]  aluFunc;
    typedef logic [2:0]  stageEnable;   // Bit 0 ID/EX, bit 1 EX/MEM, bit 2 MEM/WB

    localparam opCode OpSpecial = 6'b000000;   // R-type and JR
    localparam opCode OpRegImm  = 6'b000001;   // BGEZ, BLTZ
    localparam opCode OpJ       = 6'b000010;
    localparam opCode OpJal     = 6'b000011;
    localparam opCode OpBeq     = 6'b000100;
    localparam opCode OpBne     = 6'b000101;
    localparam opCode OpBlez    = 6'b000110;
    localparam opCode OpBgtz    = 6'b000111;
    localparam opCode OpAddi    = 6'b001000;
    localparam opCode OpAddiu   = 6'b001001;
    localparam opCode OpSlti    = 6'b001010;
    localparam opCode OpSltiu   = 6'b001011;
    localparam opCode OpAndi    = 6'b001100;
    localparam opCode OpOri     = 6'b001101;
    localparam opCode OpXori    = 6'b001110;
    localparam opCode OpLb      = 6'b100000;
    localparam opCode OpLh      = 6'b100001;
    localparam opCode OpLw      = 6'b100011;
    localparam opCode OpSb      = 6'b101000;
    localparam opCode OpSh      = 6'b101001;
    localparam opCode OpSw      = 6'b101011;

    localparam functCode FunctJr = 6'b001000;

    localparam aluOp AluOpRType = 5'b00000;   // Function field decides
    localparam aluOp AluOpAdd   = 5'b00001;
    localparam aluOp AluOpOr    = 5'b00011;
    localparam aluOp AluOpAnd   = 5'b00100;
    localparam aluOp AluOpXor   = 5'b00101;
    localparam aluOp AluOpAddu  = 5'b00111;
    localparam aluOp AluOpSlt   = 5'b01010;
    localparam aluOp AluOpSltu  = 5'b01011;
    localparam aluOp AluOpBeq   = 5'b01110;
    localparam aluOp AluOpBne   = 5'b01111;
    localparam aluOp AluOpBgez  = 5'b10000;   // Also BLTZ
    localparam aluOp AluOpBgtz  = 5'b10001;
    localparam aluOp AluOpBlez  = 5'b10010;

    localparam aluFunc FnAdd  = 4'd0;
    localparam aluFunc FnSub  = 4'd1;
    localparam aluFunc FnAnd  = 4'd2;
    localparam aluFunc FnOr   = 4'd3;
    localparam aluFunc FnXor  = 4'd4;
    localparam aluFunc FnNor  = 4'd5;
    localparam aluFunc FnSlt  = 4'd6;
    localparam aluFunc FnSltu = 4'd7;
    localparam aluFunc FnSll  = 4'd8;
    localparam aluFunc FnSrl  = 4'd9;
    localparam aluFunc FnSra  = 4'd10;

endpackage

`default_nettype wire

// File: design/DatapathController.sv
`timescale 1ns/1ps
`default_nettype none

module DatapathController (
    input  wire mipsPkg::opCode     opCode,
    input  wire mipsPkg::functCode  funct,
    output logic [1:0]              regDest,            // 0 rd, 1 rt, 2 r31
    output logic [1:0]              memToReg,           // 0 ALU, 1 memory, 2 PC+4
    output logic [1:0]              byteSel,            // 01 byte, 11 half, 00 word
    output logic                    regWrite,
    output logic                    aluSrc,
    output logic                    memWrite,
    output logic                    memRead,
    output logic                    branch,
    output logic                    signExt,
    output logic                    jump,
    output logic                    jumpReg,
    output mipsPkg::aluOp           aluOperation,
    output mipsPkg::stageEnable     stageWriteEnable
);
    import mipsPkg::*;

    logic knownOp;

    always_comb begin
        regDest      = 2'd0;
        memToReg     = 2'd0;
        byteSel      = 2'b00;
        regWrite     = 1'b0;
        aluSrc       = 1'b0;
        memWrite     = 1'b0;
        memRead      = 1'b0;
        branch       = 1'b0;
        signExt      = 1'b0;
        jump         = 1'b0;
        jumpReg      = 1'b0;
        aluOperation = AluOpRType;
        knownOp      = 1'b1;

        case (opCode)
            OpSpecial: begin
                if (funct == FunctJr) begin
                    jump    = 1'b1;
                    jumpReg = 1'b1;                     // Target comes from rs
                end else begin
                    regWrite = 1'b1;
                end
            end
            OpJ: begin
                jump         = 1'b1;
                aluOperation = AluOpAdd;
            end
            OpJal: begin
                jump         = 1'b1;
                regDest      = 2'd2;
                regWrite     = 1'b1;
                memToReg     = 2'd2;                    // Link value is PC+4
                aluOperation = AluOpAdd;
            end
            OpRegImm, OpBeq, OpBne, OpBlez, OpBgtz: begin
                branch  = 1'b1;
                signExt = 1'b1;
                case (opCode)
                    OpBeq:   aluOperation = AluOpBeq;
                    OpBne:   aluOperation = AluOpBne;
                    OpBlez:  aluOperation = AluOpBlez;
                    OpBgtz:  aluOperation = AluOpBgtz;
                    default: aluOperation = AluOpBgez;  // BGEZ or BLTZ by rt
                endcase
            end
            OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori: begin
                regDest  = 2'd1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                signExt  = ~opCode[2];                  // Logical ops zero-extend
                case (opCode)
                    OpAddi:  aluOperation = AluOpAdd;
                    OpAddiu: aluOperation = AluOpAddu;
                    OpSlti:  aluOperation = AluOpSlt;
                    OpSltiu: aluOperation = AluOpSltu;
                    OpAndi:  aluOperation = AluOpAnd;
                    OpOri:   aluOperation = AluOpOr;
                    default: aluOperation = AluOpXor;
                endcase
            end
            OpLb, OpLh, OpLw: begin
                regDest      = 2'd1;
                regWrite     = 1'b1;
                aluSrc       = 1'b1;
                memRead      = 1'b1;
                memToReg     = 2'd1;
                signExt      = 1'b1;
                aluOperation = AluOpAdd;                // Base plus offset
                byteSel      = {opCode[0] & ~opCode[1], ~opCode[1]};
            end
            OpSb, OpSh, OpSw: begin
                aluSrc       = 1'b1;
                memWrite     = 1'b1;
                signExt      = 1'b1;
                aluOperation = AluOpAdd;
                byteSel      = {opCode[0] & ~opCode[1], ~opCode[1]};  // Size from low bits
            end
            default: knownOp = 1'b0;                    // Bubble
        endcase

        stageWriteEnable = knownOp ? 3'b111 : 3'b000;
    end

endmodule

`default_nettype wire

// File: design/AluController.sv
`timescale 1ns/1ps
`default_nettype none

module AluController (
    input  wire mipsPkg::aluOp      aluOperation,
    input  wire mipsPkg::functCode  funct,
    output mipsPkg::aluFunc         aluFunction
);
    import mipsPkg::*;

    always_comb begin
        case (aluOperation)
            AluOpRType: begin
                case (funct)
                    6'b100000, 6'b100001: aluFunction = FnAdd;   // ADD, ADDU
                    6'b100010, 6'b100011: aluFunction = FnSub;   // SUB, SUBU
                    6'b100100: aluFunction = FnAnd;
                    6'b100101: aluFunction = FnOr;
                    6'b100110: aluFunction = FnXor;
                    6'b100111: aluFunction = FnNor;
                    6'b101010: aluFunction = FnSlt;
                    6'b101011: aluFunction = FnSltu;
                    6'b000000: aluFunction = FnSll;
                    6'b000010: aluFunction = FnSrl;
                    6'b000011: aluFunction = FnSra;
                    default:   aluFunction = FnAdd;              // JR and unused codes
                endcase
            end
            AluOpAdd, AluOpAddu: aluFunction = FnAdd;
            AluOpAnd:            aluFunction = FnAnd;
            AluOpOr:             aluFunction = FnOr;
            AluOpXor:            aluFunction = FnXor;
            AluOpSlt:            aluFunction = FnSlt;
            AluOpSltu:           aluFunction = FnSltu;
            AluOpBeq, AluOpBne, AluOpBgez, AluOpBgtz, AluOpBlez: begin
                aluFunction = FnSub;                             // Compare by subtraction
            end
            default: aluFunction = FnAdd;
        endcase
    end

endmodule

`default_nettype wire

// File: design/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegisterFile (
    input  wire                     Clock,
    input  wire                     arstN,
    input  wire mipsPkg::regAddr    readAddr1,
    input  wire mipsPkg::regAddr    readAddr2,
    input  wire                     writeEnable,
    input  wire mipsPkg::regAddr    writeAddr,
    input  wire mipsPkg::dataWord   writeData,
    output mipsPkg::dataWord        readData1,
    output mipsPkg::dataWord        readData2
);
    import mipsPkg::*;

    dataWord regBank [32];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regBank[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 5'd0)) begin  // Register 0 stays zero
            regBank[writeAddr] <= writeData;
        end
    end

    // Reads see the old value during a write
    assign readData1 = regBank[readAddr1];
    assign readData2 = regBank[readAddr2];

endmodule

`default_nettype wire

// File: design/NextPcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module NextPcUnit (
    input  wire mipsPkg::dataWord   pcPlus4,
    input  wire mipsPkg::dataWord   operandA,
    input  wire mipsPkg::dataWord   operandB,
    input  wire [15:0]              immediate,
    input  wire [25:0]              target,
    input  wire                     branch,
    input  wire                     jump,
    input  wire                     jumpReg,
    input  wire mipsPkg::aluOp      aluOperation,
    input  wire mipsPkg::regAddr    rtField,
    output logic                    branchTaken,
    output mipsPkg::dataWord        branchTarget,
    output mipsPkg::dataWord        jumpTarget,
    output logic                    ifIdFlush
);
    import mipsPkg::*;

    logic               conditionMet;
    logic signed [31:0] signedA;
    dataWord            branchOffset;

    assign signedA = operandA;

    always_comb begin
        case (aluOperation)
            AluOpBeq:  conditionMet = (operandA == operandB);
            AluOpBne:  conditionMet = (operandA != operandB);
            AluOpBlez: conditionMet = (signedA <= 0);
            AluOpBgtz: conditionMet = (signedA > 0);
            AluOpBgez: conditionMet = rtField[0] ? (signedA >= 0) : (signedA < 0);  // rt 1 BGEZ
            default:   conditionMet = 1'b0;
        endcase
    end

    assign branchTaken  = branch && conditionMet;
    assign ifIdFlush    = branchTaken || jump;     // Drop the fetched slot

    assign branchOffset = {{14{immediate[15]}}, immediate, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;
    assign jumpTarget   = jumpReg ? operandA : {pcPlus4[31:28], target, 2'b00};

endmodule

`default_nettype wire

// File: design/DecodeLatch.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeLatch (
    input  wire                         Clock,
    input  wire                         arstN,
    input  wire                         stall,
    input  wire [1:0]                   regDest,
    input  wire                         regWrite,
    input  wire                         aluSrc,
    input  wire                         memWrite,
    input  wire                         memRead,
    input  wire [1:0]                   memToReg,
    input  wire                         signExt,
    input  wire [1:0]                   byteSel,
    input  wire mipsPkg::stageEnable    stageWriteEnable,
    input  wire mipsPkg::aluFunc        aluFunction,
    input  wire mipsPkg::dataWord       readData1,
    input  wire mipsPkg::dataWord       readData2,
    input  wire [15:0]                  immediate,
    input  wire mipsPkg::regAddr        rtField,
    input  wire mipsPkg::regAddr        rdField,
    input  wire mipsPkg::dataWord       pcPlus4,
    output logic                        idExRegWrite,
    output logic                        idExMemRead,
    output logic                        idExMemWrite,
    output logic [1:0]                  idExMemToReg,
    output logic                        idExAluSrc,
    output logic [1:0]                  idExByteSel,
    output mipsPkg::aluFunc             idExAluFunc,
    output mipsPkg::dataWord            idExReadData1,
    output mipsPkg::dataWord            idExReadData2,
    output mipsPkg::dataWord            idExImmediate,
    output mipsPkg::regAddr             idExDestReg,
    output mipsPkg::dataWord            idExPcPlus4,
    output mipsPkg::stageEnable         idExStageWriteEnable
);
    import mipsPkg::*;

    dataWord extImmediate;
    regAddr  destReg;

    assign extImmediate = signExt ? {{16{immediate[15]}}, immediate} : {16'h0000, immediate};

    always_comb begin
        case (regDest)
            2'd1:    destReg = rtField;
            2'd2:    destReg = 5'd31;               // JAL link register
            default: destReg = rdField;
        endcase
    end

    // Unknown opcodes arrive with zero controls and pass on as a bubble
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            idExRegWrite         <= 1'b0;
            idExMemRead          <= 1'b0;
            idExMemWrite         <= 1'b0;
            idExMemToReg         <= 2'd0;
            idExAluSrc           <= 1'b0;
            idExByteSel          <= 2'b00;
            idExAluFunc          <= FnAdd;
            idExStageWriteEnable <= 3'b000;
        end else if (!stall) begin
            idExRegWrite         <= regWrite;
            idExMemRead          <= memRead;
            idExMemWrite         <= memWrite;
            idExMemToReg         <= memToReg;
            idExAluSrc           <= aluSrc;
            idExByteSel          <= byteSel;
            idExAluFunc          <= aluFunction;
            idExStageWriteEnable <= stageWriteEnable;
        end
    end

    always_ff @(posedge Clock) begin
        if (!stall) begin
            idExReadData1 <= readData1;
            idExReadData2 <= readData2;
            idExImmediate <= extImmediate;
            idExDestReg   <= destReg;
            idExPcPlus4   <= pcPlus4;
        end
    end

endmodule

`default_nettype wire

// File: design/DecodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeStage (
    input  wire                         Clock,
    input  wire                         arstN,
    input  wire mipsPkg::dataWord       instruction,
    input  wire mipsPkg::dataWord       pcPlus4,
    input  wire                         stall,
    input  wire                         wbWrite,
    input  wire mipsPkg::regAddr        wbAddr,
    input  wire mipsPkg::dataWord       wbData,
    output logic                        idExRegWrite,
    output logic                        idExMemRead,
    output logic                        idExMemWrite,
    output logic [1:0]                  idExMemToReg,
    output logic                        idExAluSrc,
    output logic [1:0]                  idExByteSel,
    output mipsPkg::aluFunc             idExAluFunc,
    output mipsPkg::dataWord            idExReadData1,
    output mipsPkg::dataWord            idExReadData2,
    output mipsPkg::dataWord            idExImmediate,
    output mipsPkg::regAddr             idExDestReg,
    output mipsPkg::dataWord            idExPcPlus4,
    output mipsPkg::stageEnable         idExStageWriteEnable,
    output logic                        branchTaken,
    output mipsPkg::dataWord            branchTarget,
    output logic                        jump,
    output mipsPkg::dataWord            jumpTarget,
    output logic                        ifIdFlush
);
    import mipsPkg::*;

    logic [1:0] regDest;
    logic [1:0] memToReg;
    logic [1:0] byteSel;
    logic       regWrite;
    logic       aluSrc;
    logic       memWrite;
    logic       memRead;
    logic       branch;
    logic       signExt;
    logic       jumpReg;
    aluOp       aluOperation;
    stageEnable stageWriteEnable;
    aluFunc     aluFunction;
    dataWord    readData1;
    dataWord    readData2;

    DatapathController i_DatapathController (
        .opCode (instruction[31:26]),
        .funct  (instruction[5:0]),
        .*
    );

    AluController i_AluController (
        .funct  (instruction[5:0]),
        .*
    );

    RegisterFile i_RegisterFile (
        .readAddr1   (instruction[25:21]),          // rs
        .readAddr2   (instruction[20:16]),          // rt
        .writeEnable (wbWrite),
        .writeAddr   (wbAddr),
        .writeData   (wbData),
        .*
    );

    NextPcUnit i_NextPcUnit (
        .operandA  (readData1),
        .operandB  (readData2),
        .immediate (instruction[15:0]),
        .target    (instruction[25:0]),
        .rtField   (instruction[20:16]),
        .*
    );

    DecodeLatch i_DecodeLatch (
        .immediate (instruction[15:0]),
        .rtField   (instruction[20:16]),
        .rdField   (instruction[15:11]),
        .*
    );

endmodule

`default_nettype wire

// File: test/DecodeStageTb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeStageTb_asserts (
    input wire                      Clock,
    input wire                      arstN,
    input wire                      branchTaken,
    input wire                      jump,
    input wire                      ifIdFlush,
    input wire                      idExMemRead,
    input wire                      idExMemWrite,
    input wire mipsPkg::stageEnable idExStageWriteEnable
);

    int failCount = 0;                          // Read by the testbench at the end

    // Flush follows a taken branch or any jump in the same cycle
    flushMatchesRedirect: assert property (@(posedge Clock) disable iff (!arstN)
        ifIdFlush == (branchTaken || jump))
        else begin
            $error("ifIdFlush differs from branchTaken or jump");
            failCount++;
        end

    memAccessExclusive: assert property (@(posedge Clock) disable iff (!arstN)
        !(idExMemRead && idExMemWrite))
        else begin
            $error("ID/EX holds a load and a store at once");
            failCount++;
        end

    resetClearsEnables: assert property (@(posedge Clock)
        $rose(arstN) |-> idExStageWriteEnable == 3'b000)
        else begin
            $error("Stage write enables not cleared by reset");
            failCount++;
        end

endmodule

bind DecodeStage DecodeStageTb_asserts i_asserts (.*);

`default_nettype wire

// File: test/DecodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module DecodeStageTb;
    import mipsPkg::*;

    localparam int MaxWait = 8;                 // Cycles allowed for one capture

    typedef enum int {
        NoFlow, FlowBeq, FlowBne, FlowBlez, FlowBgtz, FlowBgez, FlowBltz, FlowJump, FlowJr
    } flowKind;

    typedef struct {
        string      name;
        dataWord    instr;
        logic [8:0] ctrl;       // regWrite memRead memWrite memToReg aluSrc byteSel signExt
        aluFunc     func;
        int         dest;
        logic       known;      // Opcode the controller decodes
        flowKind    flow;
    } testRow;

    logic       Clock;
    logic       arstN;
    dataWord    instruction;
    dataWord    pcPlus4;
    logic       stall;
    logic       wbWrite;
    regAddr     wbAddr;
    dataWord    wbData;
    logic       idExRegWrite;
    logic       idExMemRead;
    logic       idExMemWrite;
    logic [1:0] idExMemToReg;
    logic       idExAluSrc;
    logic [1:0] idExByteSel;
    aluFunc     idExAluFunc;
    dataWord    idExReadData1;
    dataWord    idExReadData2;
    dataWord    idExImmediate;
    regAddr     idExDestReg;
    dataWord    idExPcPlus4;
    stageEnable idExStageWriteEnable;
    logic       branchTaken;
    dataWord    branchTarget;
    logic       jump;
    dataWord    jumpTarget;
    logic       ifIdFlush;

    testRow  rows[$];
    dataWord model[32];                         // Expected register contents
    string   currentTest;
    int      testErrors;
    int      mismatchTotal;
    int      testCount;
    int      failedTests;
    logic    timedOut;

    DecodeStage i_DecodeStage (.*);

    function automatic dataWord encodeR(input int rs, input int rt, input int rd,
                                        input functCode fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic dataWord encodeI(input opCode op, input int rs, input int rt,
                                        input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic dataWord encodeJ(input opCode op, input logic [25:0] target);
        return {op, target};
    endfunction

    function automatic dataWord rowPc(input int idx);
        return 32'h0040_0100 + 32'(idx) * 4;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Signed compares on the register values as MIPS defines them
    function automatic logic expectTaken(input flowKind flow, input dataWord a, input dataWord b);
        case (flow)
            FlowBeq:  return a == b;
            FlowBne:  return a != b;
            FlowBlez: return $signed(a) <= 0;
            FlowBgtz: return $signed(a) > 0;
            FlowBgez: return $signed(a) >= 0;
            FlowBltz: return $signed(a) < 0;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic addRow(input string name, input dataWord instr, input logic [8:0] ctrl,
                          input aluFunc func, input int dest, input logic known,
                          input flowKind flow);
        rows.push_back('{name, instr, ctrl, func, dest, known, flow});
    endtask

    task automatic check(input string field, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     currentTest, field, expected, actual);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        testErrors  = 0;
    endtask

    task automatic finishTest();
        testCount++;
        mismatchTotal += testErrors;
        if (testErrors == 0) begin
            $display("%-12s ok", currentTest);
        end else begin
            $display("%-12s failed with %0d mismatches", currentTest, testErrors);
            failedTests++;
        end
    endtask

    task automatic checkLatched(input int idx);
        testRow  row;
        dataWord imm;
        row = rows[idx];
        imm = {{16{row.ctrl[0] & row.instr[15]}}, row.instr[15:0]};   // Sign or zero fill
        check("regWrite", row.ctrl[8], idExRegWrite);
        check("memRead", row.ctrl[7], idExMemRead);
        check("memWrite", row.ctrl[6], idExMemWrite);
        check("memToReg", row.ctrl[5:4], idExMemToReg);
        check("aluSrc", row.ctrl[3], idExAluSrc);
        check("byteSel", row.ctrl[2:1], idExByteSel);
        check("aluFunc", row.func, idExAluFunc);
        check("destReg", row.dest, idExDestReg);
        check("immediate", imm, idExImmediate);
        check("readData1", model[row.instr[25:21]], idExReadData1);
        check("readData2", model[row.instr[20:16]], idExReadData2);
        check("pcPlus4", rowPc(idx), idExPcPlus4);
        check("stageWriteEnable", row.known ? 3'b111 : 3'b000, idExStageWriteEnable);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic runRow(input int idx);
        testRow  row;
        dataWord pc;
        dataWord a;
        logic    taken;
        logic    jumps;
        int      cycles;
        row   = rows[idx];
        pc    = rowPc(idx);
        a     = model[row.instr[25:21]];
        taken = expectTaken(row.flow, a, model[row.instr[20:16]]);
        jumps = (row.flow == FlowJump) || (row.flow == FlowJr);
        startTest(row.name);
        instruction = row.instr;
        pcPlus4     = pc;
        cycles      = 0;
        do begin
            @(negedge Clock);
            cycles++;
        end while (idExPcPlus4 !== pc && cycles < MaxWait);
        if (idExPcPlus4 !== pc) begin
            $display("Timeout in %s: the ID/EX register never took the instruction", row.name);
            timedOut = 1'b1;
            testErrors++;
        end
        check("latency", 1, cycles);
        checkLatched(idx);
        check("branchTaken", taken, branchTaken);
        check("jump", jumps, jump);
        check("ifIdFlush", taken || jumps, ifIdFlush);
        if (row.flow >= FlowBeq && row.flow <= FlowBltz) begin
            check("branchTarget", pc + 32'($signed(row.instr[15:0])) * 4, branchTarget);
        end
        if (row.flow == FlowJump) begin
            check("jumpTarget", (pc & 32'hf000_0000) | (32'(row.instr[25:0]) << 2),
                  jumpTarget);
        end
        if (row.flow == FlowJr) begin
            check("jumpTarget", a, jumpTarget);
        end
        finishTest();
    endtask

    // ID/EX keeps one entry while another instruction waits at the input
    task automatic stallHold(input int holdIdx, input int nextIdx);
        runRow(holdIdx);
        startTest("stall_hold");
        stall       = 1'b1;
        instruction = rows[nextIdx].instr;
        pcPlus4     = rowPc(nextIdx);
        repeat (3) begin
            @(negedge Clock);
            checkLatched(holdIdx);
        end
        stall = 1'b0;
        finishTest();
        runRow(nextIdx);
    endtask

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    initial begin
        logic [31:0] seed;
        arstN       = 1'b0;
        instruction = '0;
        pcPlus4     = '0;
        stall       = 1'b0;
        wbWrite     = 1'b0;
        wbAddr      = '0;
        wbData      = '0;
        timedOut    = 1'b0;
        testCount   = 0;
        failedTests = 0;
        mismatchTotal = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end

        addRow("regs_reset", encodeR(5, 6, 7, 6'h20), 9'b1_0_0_00_0_00_0, FnAdd, 7, 1, NoFlow);
        addRow("add", encodeR(1, 2, 3, 6'h20), 9'b1_0_0_00_0_00_0, FnAdd, 3, 1, NoFlow);
        addRow("nor", encodeR(7, 8, 9, 6'h27), 9'b1_0_0_00_0_00_0, FnNor, 9, 1, NoFlow);
        addRow("sltu", encodeR(10, 11, 12, 6'h2b), 9'b1_0_0_00_0_00_0, FnSltu, 12, 1, NoFlow);
        addRow("sra", encodeR(0, 13, 14, 6'h03), 9'b1_0_0_00_0_00_0, FnSra, 14, 1, NoFlow);
        addRow("r0_read", encodeR(0, 0, 15, 6'h22), 9'b1_0_0_00_0_00_0, FnSub, 15, 1, NoFlow);
        addRow("addi", encodeI(OpAddi, 1, 16, 16'h8001), 9'b1_0_0_00_1_00_1, FnAdd, 16, 1,
               NoFlow);
        addRow("slti", encodeI(OpSlti, 2, 17, 16'hfff0), 9'b1_0_0_00_1_00_1, FnSlt, 17, 1,
               NoFlow);
        addRow("andi", encodeI(OpAndi, 3, 18, 16'h8f0f), 9'b1_0_0_00_1_00_0, FnAnd, 18, 1,
               NoFlow);
        addRow("ori", encodeI(OpOri, 4, 19, 16'hf00f), 9'b1_0_0_00_1_00_0, FnOr, 19, 1, NoFlow);
        addRow("xori", encodeI(OpXori, 5, 20, 16'habcd), 9'b1_0_0_00_1_00_0, FnXor, 20, 1,
               NoFlow);
        addRow("lb", encodeI(OpLb, 4, 21, 16'h0010), 9'b1_1_0_01_1_01_1, FnAdd, 21, 1, NoFlow);
        addRow("lh", encodeI(OpLh, 4, 22, 16'hfffe), 9'b1_1_0_01_1_11_1, FnAdd, 22, 1, NoFlow);
        addRow("lw", encodeI(OpLw, 6, 23, 16'h0020), 9'b1_1_0_01_1_00_1, FnAdd, 23, 1, NoFlow);
        addRow("sb", encodeI(OpSb, 4, 24, 16'h0008), 9'b0_0_1_00_1_01_1, FnAdd, 0, 1, NoFlow);
        addRow("sh", encodeI(OpSh, 4, 25, 16'hfffc), 9'b0_0_1_00_1_11_1, FnAdd, 31, 1, NoFlow);
        addRow("sw", encodeI(OpSw, 6, 26, 16'h0020), 9'b0_0_1_00_1_00_1, FnAdd, 0, 1, NoFlow);
        addRow("beq", encodeI(OpBeq, 3, 3, 16'h0004), 9'b0_0_0_00_0_00_1, FnSub, 0, 1, FlowBeq);
        addRow("bne", encodeI(OpBne, 3, 4, 16'hfffc), 9'b0_0_0_00_0_00_1, FnSub, 31, 1, FlowBne);
        addRow("blez", encodeI(OpBlez, 0, 0, 16'h0002), 9'b0_0_0_00_0_00_1, FnSub, 0, 1,
               FlowBlez);
        addRow("bgtz", encodeI(OpBgtz, 7, 0, 16'h0010), 9'b0_0_0_00_0_00_1, FnSub, 0, 1,
               FlowBgtz);
        addRow("bgez", encodeI(OpRegImm, 8, 1, 16'h0003), 9'b0_0_0_00_0_00_1, FnSub, 0, 1,
               FlowBgez);
        addRow("bltz", encodeI(OpRegImm, 8, 0, 16'h8000), 9'b0_0_0_00_0_00_1, FnSub, 16, 1,
               FlowBltz);
        addRow("j", encodeJ(OpJ, 26'h0100040), 9'b0_0_0_00_0_00_0, FnAdd, 0, 1, FlowJump);
        addRow("jal", encodeJ(OpJal, 26'h0100080), 9'b1_0_0_10_0_00_0, FnAdd, 31, 1, FlowJump);
        addRow("jr", encodeR(9, 0, 0, 6'h08), 9'b0_0_0_00_0_00_0, FnAdd, 0, 1, FlowJr);
        addRow("bubble", encodeI(6'h3f, 1, 2, 16'h1820), 9'b0_0_0_00_0_00_0, FnAdd, 3, 0, NoFlow);

        repeat (8) @(negedge Clock);
        arstN = 1'b1;

        startTest("reset");
        check("controls", '0, {idExRegWrite, idExMemRead, idExMemWrite, idExMemToReg,
                               idExAluSrc, idExByteSel, idExStageWriteEnable});
        finishTest();
        runRow(0);                              // All registers still zero

        // Fill every register, r0 included, through the write-back port
        seed = 32'h5193aeda;
        for (int r = 0; r < 32; r++) begin
            seed     = xorshift(seed);
            wbWrite  = 1'b1;
            wbAddr   = 5'(r);
            wbData   = seed;
            model[r] = (r == 0) ? '0 : seed;
            @(negedge Clock);
        end
        wbWrite = 1'b0;

        for (int i = 1; i < rows.size() && !timedOut; i++) begin
            runRow(i);
        end
        if (!timedOut) begin
            stallHold(6, 13);                   // addi held, lw waiting
        end

        $display("Tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 testCount, failedTests, mismatchTotal, i_DecodeStage.i_asserts.failCount);
        if (failedTests == 0 && i_DecodeStage.i_asserts.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/mipsPkg.sv
design/DatapathController.sv
design/AluController.sv
design/RegisterFile.sv
design/NextPcUnit.sv
design/DecodeLatch.sv
design/DecodeStage.sv
test/DecodeStageTb_asserts.sv
test/DecodeStageTb.sv
